//--- design/boot_rom.sv
// image comes from rom.hex in the run directory; unlisted words read back as unknown
`timescale 1ns/1ps

module boot_rom (
	input  logic [fwsoc_pkg::rom_index_w-1:0] iindex,
	input  logic [fwsoc_pkg::rom_index_w-1:0] dindex,
	output logic [31:0]                       idata,
	output logic [31:0]                       ddata
);

	logic [31:0] rom [0:fwsoc_pkg::rom_words-1];

	initial begin
		$readmemh("rom.hex", rom); // boot image
	end

	assign idata = rom[iindex]; // fetch port
	assign ddata = rom[dindex]; // load port, also periph reads

endmodule

//--- design/byte_lane_ram.sv
// no reset on contents, reads are combinational so the array maps to LUT RAM on most parts
`timescale 1ns/1ps

module byte_lane_ram (
	input  logic                              clock4,
	input  logic [3:0]                        we,
	input  logic [fwsoc_pkg::ram_index_w-1:0] windex,
	input  logic [31:0]                       wdata,
	input  logic [fwsoc_pkg::ram_index_w-1:0] iindex,
	input  logic [fwsoc_pkg::ram_index_w-1:0] dindex,
	output logic [31:0]                       idata,
	output logic [31:0]                       ddata
);

	// lane g holds byte g of every word
	for (genvar g = 0; g < 4; g++) begin : g_lane
		logic [7:0] mem [0:fwsoc_pkg::ram_words-1];

		always_ff @(posedge clock4) begin
			if (we[g]) begin
				mem[windex] <= wdata[8*g +: 8]; // only strobed bytes
			end
		end

		// two read ports share the lane
		assign idata[8*g +: 8] = mem[iindex];
		assign ddata[8*g +: 8] = mem[dindex];
	end

endmodule

//--- design/fwsoc_pkg.sv
// address map for the fabric; ROM and RAM share region 8, RAM is bank 2 only, no other decode
package fwsoc_pkg;

	// region codes, address bits 31..28
	localparam logic [3:0] region_ram    = 4'h8;
	localparam logic [3:0] region_rom    = 4'h8; // same region as RAM, bank picks
	localparam logic [3:0] region_periph = 4'hC;

	// bits 15..12 inside region 8 that select RAM
	localparam logic [3:0] ram_bank = 4'h2;

	// array depths
	localparam int ram_words = 1024; // 4 KB
	localparam int rom_words = 4096; // 16 KB

	localparam int ram_index_w = 10;
	localparam int rom_index_w = 12;

	// register selects, address bits 3..2
	localparam logic [1:0] periph_led = 2'd0;
	localparam logic [1:0] periph_tx  = 2'd1;

	// one bus address, read three ways depending on target
	typedef union packed {
		struct packed {
			logic [3:0]             region;
			logic [13:0]            pad;    // bits 27..14, ignored
			logic [rom_index_w-1:0] index;  // bits 13..2
			logic [1:0]             offset;
		} rom;
		struct packed {
			logic [3:0]             region;
			logic [11:0]            pad;    // bits 27..16
			logic [3:0]             bank;   // bits 15..12
			logic [ram_index_w-1:0] index;  // bits 11..2
			logic [1:0]             offset;
		} ram;
		struct packed {
			logic [3:0]  region;
			logic [23:0] pad;
			logic [1:0]  sel;    // register select
			logic [1:0]  offset;
		} periph;
	} mem_addr_u;

endpackage

//--- design/fwsoc_top.sv
// core lives outside; fabric runs straight off clock4 with rst_n as the only reset
`timescale 1ns/1ps

module fwsoc_top (
	input  logic        clock4,
	input  logic        rst_n,
	input  logic [31:0] iaddr,
	input  logic        ivalid,
	output logic [31:0] idata,
	output logic        iready,
	input  logic [31:0] daddr,
	input  logic [31:0] dwdata,
	input  logic [3:0]  dwstb,
	input  logic        dwrite,
	input  logic        dvalid,
	output logic [31:0] drdata,
	output logic        dready,
	output logic        led0,
	output logic        led1,
	output logic        d0_n,
	output logic        tx
);

	// RAM side
	logic [3:0]                        ram_we;
	logic [fwsoc_pkg::ram_index_w-1:0] ram_windex;
	logic [31:0]                       ram_wdata;
	logic [fwsoc_pkg::ram_index_w-1:0] ram_iindex;
	logic [fwsoc_pkg::ram_index_w-1:0] ram_dindex;
	logic [31:0]                       ram_idata;
	logic [31:0]                       ram_ddata;
	// ROM side
	logic [fwsoc_pkg::rom_index_w-1:0] rom_iindex;
	logic [fwsoc_pkg::rom_index_w-1:0] rom_dindex;
	logic [31:0]                       rom_idata;
	logic [31:0]                       rom_ddata;
	// peripherals
	logic                              periph_we;
	logic [1:0]                        periph_sel;
	logic [31:0]                       periph_wdata;

	mem_fabric u_fabric (
		.clock4       (clock4),
		.rst_n        (rst_n),
		.iaddr        (iaddr),
		.ivalid       (ivalid),
		.iready       (iready),
		.idata        (idata),
		.daddr        (daddr),
		.dwdata       (dwdata),
		.dwstb        (dwstb),
		.dwrite       (dwrite),
		.dvalid       (dvalid),
		.dready       (dready),
		.drdata       (drdata),
		.ram_we       (ram_we),
		.ram_windex   (ram_windex),
		.ram_wdata    (ram_wdata),
		.ram_iindex   (ram_iindex),
		.ram_dindex   (ram_dindex),
		.ram_idata    (ram_idata),
		.ram_ddata    (ram_ddata),
		.rom_iindex   (rom_iindex),
		.rom_dindex   (rom_dindex),
		.rom_idata    (rom_idata),
		.rom_ddata    (rom_ddata),
		.periph_we    (periph_we),
		.periph_sel   (periph_sel),
		.periph_wdata (periph_wdata)
	);

	byte_lane_ram u_ram (
		.clock4 (clock4),
		.we     (ram_we),
		.windex (ram_windex),
		.wdata  (ram_wdata),
		.iindex (ram_iindex),
		.dindex (ram_dindex),
		.idata  (ram_idata),
		.ddata  (ram_ddata)
	);

	boot_rom u_rom (
		.iindex (rom_iindex),
		.dindex (rom_dindex),
		.idata  (rom_idata),
		.ddata  (rom_ddata)
	);

	periph_regs u_periph (
		.clock4 (clock4),
		.rst_n  (rst_n),
		.we     (periph_we),
		.sel    (periph_sel),
		.wdata  (periph_wdata),
		.led0   (led0),
		.led1   (led1),
		.d0_n   (d0_n),
		.tx     (tx)
	);

endmodule

//--- design/mem_fabric.sv
// data port always wins; instruction requests stall while dvalid is high, periph reads give ROM data
`timescale 1ns/1ps

module mem_fabric (
	input  logic                               clock4,
	input  logic                               rst_n,
	input  logic [31:0]                        iaddr,
	input  logic                               ivalid,
	output logic                               iready,
	output logic [31:0]                        idata,
	input  logic [31:0]                        daddr,
	input  logic [31:0]                        dwdata,
	input  logic [3:0]                         dwstb,
	input  logic                               dwrite,
	input  logic                               dvalid,
	output logic                               dready,
	output logic [31:0]                        drdata,
	output logic [3:0]                         ram_we,
	output logic [fwsoc_pkg::ram_index_w-1:0]  ram_windex,
	output logic [31:0]                        ram_wdata,
	output logic [fwsoc_pkg::ram_index_w-1:0]  ram_iindex,
	output logic [fwsoc_pkg::ram_index_w-1:0]  ram_dindex,
	input  logic [31:0]                        ram_idata,
	input  logic [31:0]                        ram_ddata,
	output logic [fwsoc_pkg::rom_index_w-1:0]  rom_iindex,
	output logic [fwsoc_pkg::rom_index_w-1:0]  rom_dindex,
	input  logic [31:0]                        rom_idata,
	input  logic [31:0]                        rom_ddata,
	output logic                               periph_we,
	output logic [1:0]                         periph_sel,
	output logic [31:0]                        periph_wdata
);

	fwsoc_pkg::mem_addr_u ia_q;   // registered fetch address
	fwsoc_pkg::mem_addr_u da_q;   // registered data address
	fwsoc_pkg::mem_addr_u da;     // live data address, for writes
	logic                 wr_fire;
	logic                 i_ram_q;
	logic                 d_ram_q;

	// RAM sits at region 8, bank 2
	function automatic logic is_ram(input fwsoc_pkg::mem_addr_u a);
		return (a.ram.region == fwsoc_pkg::region_ram) && (a.ram.bank == fwsoc_pkg::ram_bank);
	endfunction

	// ready flags, one cycle after valid
	always_ff @(posedge clock4 or negedge rst_n) begin
		if (!rst_n) begin
			iready <= 1'b0;
			dready <= 1'b0;
		end else if (dvalid) begin
			dready <= 1'b1; // data first
			iready <= 1'b0;
		end else begin
			dready <= 1'b0;
			iready <= ivalid;
		end
	end

	// address regs, sampled every edge
	always_ff @(posedge clock4) begin
		ia_q <= iaddr;
		da_q <= daddr;
	end

	assign da      = daddr;
	assign wr_fire = dvalid && dready && dwrite; // write edge

	assign i_ram_q = is_ram(ia_q);
	assign d_ram_q = is_ram(da_q);

	// read side indices
	assign ram_iindex = ia_q.ram.index;
	assign ram_dindex = da_q.ram.index;
	assign rom_iindex = ia_q.rom.index;
	assign rom_dindex = da_q.rom.index;

	// write side, live address
	assign ram_we     = dwstb & {4{wr_fire && is_ram(da)}};
	assign ram_windex = da.ram.index;
	assign ram_wdata  = dwdata;

	assign periph_we    = wr_fire && (da.periph.region == fwsoc_pkg::region_periph);
	assign periph_sel   = da.periph.sel;
	assign periph_wdata = dwdata;

	// return mux, anything not RAM reads ROM
	assign idata  = i_ram_q ? ram_idata : rom_idata;
	assign drdata = d_ram_q ? ram_ddata : rom_ddata;

	a_one_ready: assert property (@(posedge clock4) disable iff (!rst_n)
		!(iready && dready));

	a_dready_cause: assert property (@(posedge clock4) disable iff (!rst_n)
		$rose(dready) |-> $past(dvalid));

	// fetch only granted when data port was idle
	a_iready_cause: assert property (@(posedge clock4) disable iff (!rst_n)
		$rose(iready) |-> $past(ivalid && !dvalid));

endmodule

//--- design/periph_regs.sv
// write-only LED and TX words; only LED bits 0, 1, 3 and TX bit 0 reach pins
`timescale 1ns/1ps

module periph_regs (
	input  logic        clock4,
	input  logic        rst_n,
	input  logic        we,
	input  logic [1:0]  sel,
	input  logic [31:0] wdata,
	output logic        led0,
	output logic        led1,
	output logic        d0_n,
	output logic        tx
);

	logic [31:0] led_q;
	logic [31:0] tx_q;

	always_ff @(posedge clock4 or negedge rst_n) begin
		if (!rst_n) begin
			led_q <= '0;
			tx_q  <= '0;
		end else if (we) begin
			// selects 2 and 3 do nothing
			if (sel == fwsoc_pkg::periph_led) begin
				led_q <= wdata;
			end else if (sel == fwsoc_pkg::periph_tx) begin
				tx_q <= wdata;
			end
		end
	end

	assign led0 = led_q[0];
	assign led1 = led_q[1];
	assign d0_n = led_q[3]; // bit 2 not pinned out
	assign tx   = tx_q[0];  // serial line, bit-banged by software

	// pins quiet during reset
	a_pins_reset: assert property (@(posedge clock4)
		!rst_n |-> !(led0 || led1 || d0_n || tx));

endmodule

//--- dv/fwsoc_tb.sv
// plays the core on both ports; needs rom.hex in the run directory, ROM reads stay in its loaded words
`timescale 1ns/1ps

module fwsoc_tb;

	localparam int clk_period   = 100;
	localparam int ready_limit  = 8;   // cycles before a transfer is given up
	localparam int n_rom        = 200;
	localparam int n_pool       = 32;  // RAM words that are written in full first
	localparam int n_ram_writes = 300;
	localparam int n_ram_reads  = n_ram_writes / 2;
	localparam int n_ram_fetch  = 60;
	localparam int n_prio       = 20;  // two transfers each
	localparam int n_periph     = 48;
	localparam int total_xfers  = n_rom + n_pool + n_ram_writes + n_ram_reads
		+ n_ram_fetch + 2 * n_prio + n_periph;
	localparam int rom_lo_words = 100; // words 0..99 and ff0..fff are loaded

	logic        clock4;
	logic        rst_n;
	logic [31:0] iaddr;
	logic        ivalid;
	logic [31:0] idata;
	logic        iready;
	logic [31:0] daddr;
	logic [31:0] dwdata;
	logic [3:0]  dwstb;
	logic        dwrite;
	logic        dvalid;
	logic [31:0] drdata;
	logic        dready;
	logic        led0;
	logic        led1;
	logic        d0_n;
	logic        tx;

	// reference model
	logic [31:0] rom_model [0:fwsoc_pkg::rom_words-1];
	logic [31:0] ram_model [0:fwsoc_pkg::ram_words-1];
	logic [31:0] led_model;
	logic [31:0] tx_model;
	logic [9:0]  pool [$]; // RAM indices with known contents

	int errors;
	int checks;
	int tests_run;
	int test_errors;
	int test_checks;
	int overlaps;          // owned by the grant monitor

	fwsoc_top DUT (
		.clock4 (clock4),
		.rst_n  (rst_n),
		.iaddr  (iaddr),
		.ivalid (ivalid),
		.idata  (idata),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.dwstb  (dwstb),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.drdata (drdata),
		.dready (dready),
		.led0   (led0),
		.led1   (led1),
		.d0_n   (d0_n),
		.tx     (tx)
	);

	initial begin
		clock4 = 1'b0;
		forever #(clk_period / 2) clock4 = ~clock4;
	end

	// grants are exclusive at all times
	initial begin
		overlaps = 0;
		forever begin
			@(negedge clock4);
			if (rst_n && iready && dready) begin
				$display("iready and dready both high at %0t", $time);
				overlaps++;
			end
		end
	end

	// run limit scales with the transfer count
	initial begin
		#(total_xfers * 10 * clk_period);
		$display("watchdog expired after %0d cycles, run did not complete", total_xfers * 10);
		$display("Errors found");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		test_checks++;
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d failed", name, test_checks, test_errors);
		checks      += test_checks;
		errors      += test_errors;
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic check_idle_outputs(input string tag);
		check_value({tag, " iready"}, 32'd0, {31'd0, iready});
		check_value({tag, " dready"}, 32'd0, {31'd0, dready});
		check_value({tag, " led0"}, 32'd0, {31'd0, led0});
		check_value({tag, " led1"}, 32'd0, {31'd0, led1});
		check_value({tag, " d0_n"}, 32'd0, {31'd0, d0_n});
		check_value({tag, " tx"}, 32'd0, {31'd0, tx});
	endtask

	// data transfer holds valid until dready is seen, then idles a cycle
	task automatic data_access(input logic [31:0] addr, input logic write,
		input logic [31:0] wdata, input logic [3:0] stb, output logic [31:0] rdata);
		int waited;
		waited = 0;
		daddr  = addr;
		dwrite = write;
		dwdata = wdata;
		dwstb  = stb;
		dvalid = 1'b1;
		@(negedge clock4);
		while (!dready && waited < ready_limit) begin
			waited++;
			@(negedge clock4);
		end
		if (!dready) begin
			$display("data transfer to %h got no dready in %0d cycles", addr, ready_limit);
			test_errors++;
		end
		rdata = drdata;  // registered address already matches
		@(negedge clock4); // completing rising edge has passed
		dvalid = 1'b0;
		dwrite = 1'b0;
		@(negedge clock4); // dready back low
	endtask

	task automatic inst_fetch(input logic [31:0] addr, output logic [31:0] rdata);
		int waited;
		waited = 0;
		iaddr  = addr;
		ivalid = 1'b1;
		@(negedge clock4);
		while (!iready && waited < ready_limit) begin
			waited++;
			@(negedge clock4);
		end
		if (!iready) begin
			$display("fetch from %h got no iready in %0d cycles", addr, ready_limit);
			test_errors++;
		end
		rdata = idata;
		@(negedge clock4);
		ivalid = 1'b0;
		@(negedge clock4);
	endtask

	// RAM is region 8 with bank 2 and anything else reads ROM
	function automatic logic [31:0] model_read(input logic [31:0] addr);
		if (addr[31:28] == 4'h8 && addr[15:12] == 4'h2) begin
			return ram_model[addr[11:2]];
		end
		return rom_model[addr[13:2]];
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] wd, input logic [3:0] stb);
		logic [31:0] w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (stb[b]) begin
				w[8*b +: 8] = wd[8*b +: 8]; // strobed lanes only
			end
		end
		return w;
	endfunction

	function automatic logic [31:0] ram_addr(input logic [9:0] idx);
		logic [31:0] r;
		r = $urandom; // random pad bits 27..16
		return {fwsoc_pkg::region_ram, r[11:0], fwsoc_pkg::ram_bank, idx, 2'b00};
	endfunction

	// index bits 11..10 are never 10 here, so bits 15..12 cannot hit the RAM bank
	function automatic logic [31:0] rom_addr(input logic [11:0] idx);
		logic [31:0] r;
		r = $urandom;
		return {r[31:28], r[13:0], idx, 2'b00};
	endfunction

	function automatic logic [11:0] pick_rom_index();
		logic [31:0] r;
		logic [31:0] m;
		r = $urandom;
		if (r[31:30] == 2'b00) begin
			return 12'hff0 | {8'd0, r[3:0]}; // top block of the image
		end
		m = r % rom_lo_words;
		return m[11:0];
	endfunction

	initial begin
		logic [31:0] r;
		logic [31:0] wd;
		logic [31:0] rd;
		logic [31:0] addr;
		logic [9:0]  idx;
		int          sel;
		int          hold;
		int          waited;
		void'($urandom(80));
		rst_n  = 1'b1;
		iaddr  = '0;
		ivalid = 1'b0;
		daddr  = '0;
		dwdata = '0;
		dwstb  = '0;
		dwrite = 1'b0;
		dvalid = 1'b0;
		errors = 0;
		checks = 0;
		tests_run   = 0;
		test_errors = 0;
		test_checks = 0;
		led_model   = '0;
		tx_model    = '0;
		$readmemh("rom.hex", rom_model);
		#(clk_period / 4) rst_n = 1'b0; // clean edge before the first clock

		repeat (3) begin
			@(negedge clock4);
			check_idle_outputs("in reset");
		end
		rst_n = 1'b1;
		@(negedge clock4); // first rising edge out of reset
		check_idle_outputs("after reset");
		end_test("reset");

		for (int i = 0; i < n_rom; i++) begin
			addr = rom_addr(pick_rom_index());
			inst_fetch(addr, rd);
			check_value("rom fetch", model_read(addr), rd);
		end
		end_test("rom fetch");

		for (int i = 0; i < n_pool; i++) begin
			r  = $urandom;
			wd = $urandom;
			pool.push_back(r[9:0]);
			data_access(ram_addr(r[9:0]), 1'b1, wd, 4'hf, rd); // full word first
			ram_model[r[9:0]] = wd;
		end
		for (int i = 0; i < n_ram_writes; i++) begin
			r   = $urandom;
			wd  = $urandom;
			sel = r % n_pool;
			idx = pool[sel];
			data_access(ram_addr(idx), 1'b1, wd, r[31:28], rd);
			ram_model[idx] = merge_bytes(ram_model[idx], wd, r[31:28]);
			if (i % 2 == 1) begin
				r    = $urandom;
				sel  = r % n_pool;
				addr = ram_addr(pool[sel]);
				data_access(addr, 1'b0, 32'd0, 4'h0, rd);
				check_value("ram read", model_read(addr), rd);
			end
		end
		end_test("ram byte writes");

		for (int i = 0; i < n_ram_fetch; i++) begin
			r    = $urandom;
			sel  = r % n_pool;
			addr = ram_addr(pool[sel]);
			inst_fetch(addr, rd);
			check_value("ram fetch", model_read(addr), rd);
		end
		end_test("ram fetch");

		for (int i = 0; i < n_prio; i++) begin
			r      = $urandom;
			sel    = r % n_pool;
			hold   = int'(r[31:30]); // extra cycles dvalid stays up
			iaddr  = (i % 2 == 0) ? rom_addr(pick_rom_index()) : ram_addr(pool[sel]);
			daddr  = ram_addr(pool[n_pool - 1 - sel]);
			dwrite = 1'b0;
			ivalid = 1'b1;
			dvalid = 1'b1;
			@(negedge clock4);
			check_value("prio dready", 32'd1, {31'd0, dready});
			check_value("prio iready", 32'd0, {31'd0, iready});
			check_value("prio data", model_read(daddr), drdata);
			repeat (hold) begin
				@(negedge clock4);
				check_value("prio dready held", 32'd1, {31'd0, dready});
				check_value("prio iready stalled", 32'd0, {31'd0, iready});
			end
			dvalid = 1'b0; // fetch may go now
			waited = 0;
			@(negedge clock4);
			while (!iready && waited < ready_limit) begin
				waited++;
				@(negedge clock4);
			end
			if (!iready) begin
				$display("stalled fetch from %h never got iready", iaddr);
				test_errors++;
			end else begin
				check_value("prio fetch", model_read(iaddr), idata);
			end
			@(negedge clock4);
			ivalid = 1'b0;
			@(negedge clock4);
		end
		end_test("priority");

		for (int i = 0; i < n_periph; i++) begin
			r    = $urandom;
			wd   = $urandom;
			addr = {fwsoc_pkg::region_periph, r[31:8], r[1:0], 2'b00};
			data_access(addr, 1'b1, wd, r[7:4], rd); // strobe ignored here
			if (r[1:0] == 2'd0) begin
				led_model = wd;
			end else if (r[1:0] == 2'd1) begin
				tx_model = wd;
			end
			check_value("led0", {31'd0, led_model[0]}, {31'd0, led0});
			check_value("led1", {31'd0, led_model[1]}, {31'd0, led1});
			check_value("d0_n", {31'd0, led_model[3]}, {31'd0, d0_n});
			check_value("tx", {31'd0, tx_model[0]}, {31'd0, tx});
		end
		end_test("peripherals");

		errors += overlaps;
		$display("tests %0d, checks %0d, failures %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- fwsoc.f
design/fwsoc_pkg.sv
design/mem_fabric.sv
design/byte_lane_ram.sv
design/boot_rom.sv
design/periph_regs.sv
design/fwsoc_top.sv
dv/fwsoc_tb.sv

//--- rom.hex
// boot ROM image: four 32-bit hex words per line, consecutive word indices from 0
// the @ff0 line moves the last four lines to the top sixteen words; other words stay unloaded
13a57000 9f0c2001 4be81002 d2796003
0c3f4004 77e1a005 e5d02006 3a6b8007
b1947008 5ec2d009 2f08e00a 8d3b100b
61af500c c47e300d 0a95b00e f3c6700f
9b21c010 46e8f011 d07a3012 28b5d013
7c4f2014 e1936015 35da8016 a26c4017
5f170018 c8e2b019 1bd5901a 947ac01b
6e39f01c b7c4101d 03fa601e da58e01f
4281d020 fb6c3021 8e07a022 21f9b023
c5a2e024 7d3e8025 e8b15026 16d4c027
a94f1028 3c67e029 f28ad02a 57b1302b
0d6e902c 9ac4f02d 6412902e b35d702f
2e8a1030 d7f35031 49c0e032 8c27b033
f56d9034 1b38c035 a0e47036 63915037
cc7b2038 357fa039 e26c803a 7a91d03b
08d4f03c bf26103d 51e9c03e 9437a03f
6a5b8040 d1c93041 27fe6042 ec0a4043
3f71b044 84ad2045 5b26e046 c9e47047
12b8d048 a76f1049 fe3c904a 4da2504b
95e0c04c 2c7f804d d84b304e 7116904f
b3da7050 4e85c051 e7216052 1af9e053
8f43a054 c62d1055 39b8f056 a0575057
5d9ec058 f41a3059 6b83705a 02cf905b
9e6d405c 37b2e05d c1f5805e 7848b05f
e4a91060 2b7fd061 865c3062 fd1e6063
@ff0
a1c3eff0 5e7b2ff1 c8d46ff2 3940aff3
f62b1ff4 0e9d7ff5 b75c4ff6 4a83eff7
d31f9ff8 6cb58ff9 17e42ffa 8a6d0ffb
e9c57ffc 22a83ffd 7f4e1ffe c6b09fff

//--- run.sh
#!/usr/bin/env bash
# builds the fwsoc testbench with Verilator, runs it from the project root and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log
top=fwsoc_tb

rm -rf obj_dir
verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module "$top" \
	-f fwsoc.f \
	-o sim_fwsoc

./obj_dir/sim_fwsoc | tee "$log"

if grep -qx "No errors" "$log"; then
	echo "simulation passed"
else
	echo "simulation failed, see $log"
	exit 1
fi
